// File: common/mpu_pkg.sv
`default_nettype none

package mpu_pkg;

	// ====================
	// bus and sizes
	// ====================
	localparam int DATA_W      = 32;
	localparam int ADDR_W      = 32;
	localparam int PAGE_W      = 24;     // upper address bits that pick a peripheral
	localparam int REG_IDX_W   = 6;      // word index taken from adr[7:2]
	localparam int NUM_PIT_CH  = 3;
	localparam int NUM_EXT_IRQ = 29;
	localparam int NUM_IRQ     = 32;     // 0..28 external, 29..31 timer ch2..ch0
	localparam int LEVEL_W     = 4;      // interrupt priority level
	localparam int CAUSE_W     = 8;      // cause code toward the cpu

	// ====================
	// address map
	// ====================
	localparam logic [PAGE_W-1:0] PIT_PAGE = 24'hFFDC11;
	localparam logic [PAGE_W-1:0] PIC_PAGE = 24'hFFDC0F;

	// timer register offsets, word index = channel * 4 + offset
	localparam logic [1:0] PIT_REG_CTRL   = 2'd0;
	localparam logic [1:0] PIT_REG_RELOAD = 2'd1;
	localparam logic [1:0] PIT_REG_COUNT  = 2'd2;

	// interrupt controller register indices
	localparam logic [REG_IDX_W-1:0] PIC_REG_PENDING = 6'd0;  // write ones to clear
	localparam logic [REG_IDX_W-1:0] PIC_REG_ENABLE  = 6'd1;
	localparam logic [REG_IDX_W-1:0] PIC_REG_CAUSE   = 6'd2;  // read only
	localparam logic [REG_IDX_W-1:0] PIC_REG_LEVEL   = 6'd3;

	// ====================
	// fabric fsm encoding
	// ====================
	localparam logic [1:0] FAB_IDLE = 2'd0;  // waiting for a strobe
	localparam logic [1:0] FAB_WAIT = 2'd1;  // request out, waiting for an answer
	localparam logic [1:0] FAB_DONE = 2'd2;  // ack given, waiting for stb low

	// timer write word, read as control bits or as a full count value
	typedef union packed {
		struct packed {
			logic [DATA_W-3:0] rsvd;
			logic              auto_reload;   // bit 1
			logic              enable;        // bit 0
		} ctrl;
		logic [DATA_W-1:0] count;             // count or reload value
	} pit_wdata_u;

endpackage

`default_nettype wire

// File: common/periph_bus_if.sv
`default_nettype none

// single-word access path from the fabric to one peripheral
interface periph_bus_if;
	import mpu_pkg::*;

	logic                 req;   // one-cycle request pulse
	logic                 we;    // write when high
	logic [REG_IDX_W-1:0] idx;   // word index inside the peripheral
	logic [DATA_W-1:0]    wdat;
	logic                 ack;   // one cycle after req
	logic [DATA_W-1:0]    rdat;  // valid with ack

	modport fabric_mp (
		output req,
		output we,
		output idx,
		output wdat,
		input  ack,
		input  rdat
	);

	modport periph_mp (
		input  req,
		input  we,
		input  idx,
		input  wdat,
		output ack,
		output rdat
	);

endinterface

`default_nettype wire

// File: design/mpu_bus_fabric.sv
`default_nettype none

module mpu_bus_fabric (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic                       cyc_i,
	input  logic                       stb_i,
	input  logic                       we_i,
	input  logic [mpu_pkg::ADDR_W-1:0] adr_i,
	input  logic [mpu_pkg::DATA_W-1:0] dat_i,
	output logic [mpu_pkg::DATA_W-1:0] dat_o,
	output logic                       ack_o,
	output logic                       err_o,
	periph_bus_if.fabric_mp            pit_bus,
	periph_bus_if.fabric_mp            pic_bus
);
	import mpu_pkg::*;

	logic [1:0]           state_q;
	logic                 start;        // new access accepted this cycle
	logic                 hit_pit;
	logic                 hit_pic;
	logic                 resp;         // some target answered
	logic                 pit_req_q;
	logic                 pic_req_q;
	logic                 unm_req_q;    // unmapped access in flight
	logic                 unm_ack_q;    // stands in for the missing answer
	logic                 we_q;
	logic [REG_IDX_W-1:0] idx_q;
	logic [DATA_W-1:0]    wdat_q;

	// ====================
	// address decode
	// ====================
	assign hit_pit = (adr_i[ADDR_W-1 -: PAGE_W] == PIT_PAGE);
	assign hit_pic = (adr_i[ADDR_W-1 -: PAGE_W] == PIC_PAGE);
	assign start   = cyc_i && stb_i && (state_q == FAB_IDLE);
	assign resp    = pit_bus.ack | pic_bus.ack | unm_ack_q;

	// one transaction at a time
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= FAB_IDLE;
		end else begin
			case (state_q)
				FAB_IDLE: if (start) state_q <= FAB_WAIT;
				FAB_WAIT: if (resp) state_q <= FAB_DONE;    // ack_o rises next
				FAB_DONE: if (!stb_i) state_q <= FAB_IDLE;  // master has let go
				default:  state_q <= FAB_IDLE;
			endcase
		end
	end

	// request pulses, exactly one per accepted access
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			pit_req_q <= 1'b0;
			pic_req_q <= 1'b0;
			unm_req_q <= 1'b0;
			unm_ack_q <= 1'b0;
		end else begin
			pit_req_q <= start && hit_pit;
			pic_req_q <= start && hit_pic;
			unm_req_q <= start && !hit_pit && !hit_pic;
			unm_ack_q <= unm_req_q;  // same latency as a real peripheral
		end
	end

	// request payload, captured once
	always_ff @(posedge clk_i) begin
		if (start) begin
			we_q   <= we_i;
			idx_q  <= adr_i[REG_IDX_W+1:2];  // word index, adr[7:2]
			wdat_q <= dat_i;
		end
	end

	assign pit_bus.req  = pit_req_q;
	assign pit_bus.we   = we_q;
	assign pit_bus.idx  = idx_q;
	assign pit_bus.wdat = wdat_q;
	assign pic_bus.req  = pic_req_q;
	assign pic_bus.we   = we_q;
	assign pic_bus.idx  = idx_q;
	assign pic_bus.wdat = wdat_q;

	// ====================
	// response merge
	// ====================
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
			err_o <= 1'b0;
		end else begin
			ack_o <= resp;
			err_o <= unm_ack_q;  // unmapped gets ack plus error
		end
	end

	// timer wins if both ever answer, unmapped reads as zero
	always_ff @(posedge clk_i) begin
		casez ({pit_bus.ack, pic_bus.ack})
			2'b1?:   dat_o <= pit_bus.rdat;
			2'b01:   dat_o <= pic_bus.rdat;
			default: dat_o <= '0;
		endcase
	end

	// only one peripheral is ever addressed per access
	a_one_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(pit_bus.ack && pic_bus.ack));

endmodule

`default_nettype wire

// File: pit/mpu_pit.sv
`default_nettype none

module mpu_pit (
	input  logic                           clk_i,
	input  logic                           rst_n_i,
	periph_bus_if.periph_mp                bus,
	output logic [mpu_pkg::NUM_PIT_CH-1:0] pit_out_o
);
	import mpu_pkg::*;

	logic [NUM_PIT_CH-1:0] en_q;           // channel running
	logic [NUM_PIT_CH-1:0] ar_q;           // auto-reload
	logic [NUM_PIT_CH-1:0] out_q;
	logic [DATA_W-1:0]     reload_q [NUM_PIT_CH];
	logic [DATA_W-1:0]     count_q  [NUM_PIT_CH];
	logic [NUM_PIT_CH-1:0] wr_ctrl;
	logic [NUM_PIT_CH-1:0] wr_reload;
	logic [NUM_PIT_CH-1:0] wr_count;
	logic [1:0]            reg_ch;         // idx[3:2]
	logic [1:0]            reg_off;        // idx[1:0]
	logic                  reg_ok;
	pit_wdata_u            wd;             // incoming write word
	pit_wdata_u            rd_ctrl;        // control readback
	logic [DATA_W-1:0]     rd_word;
	logic                  ack_q;
	logic [DATA_W-1:0]     rdat_q;

	assign reg_ch  = bus.idx[3:2];
	assign reg_off = bus.idx[1:0];
	assign reg_ok  = (bus.idx[REG_IDX_W-1:4] == '0) && (reg_ch < NUM_PIT_CH);
	assign wd      = bus.wdat;

	// ====================
	// write decode
	// ====================
	always_comb begin
		for (int c = 0; c < NUM_PIT_CH; c++) begin
			wr_ctrl[c]   = bus.req && bus.we && reg_ok && (reg_ch == 2'(c));
			wr_reload[c] = wr_ctrl[c] && (reg_off == PIT_REG_RELOAD);
			wr_count[c]  = wr_ctrl[c] && (reg_off == PIT_REG_COUNT);
			wr_ctrl[c]   = wr_ctrl[c] && (reg_off == PIT_REG_CTRL);
		end
	end

	always_ff @(posedge clk_i) begin
		for (int c = 0; c < NUM_PIT_CH; c++) begin
			if (wr_reload[c]) reload_q[c] <= wd.count;
		end
	end

	// ====================
	// channel counters
	// ====================
	always_ff @(posedge clk_i) begin
		for (int c = 0; c < NUM_PIT_CH; c++) begin
			if (!rst_n_i) begin
				en_q[c]    <= 1'b0;
				ar_q[c]    <= 1'b0;
				out_q[c]   <= 1'b0;
				count_q[c] <= '0;
			end else begin
				if (en_q[c]) begin
					if (count_q[c] == 1) begin          // terminal count
						if (ar_q[c]) begin
							count_q[c] <= reload_q[c];  // period of exactly R clocks
						end else begin
							count_q[c] <= '0;
							en_q[c]    <= 1'b0;         // one-shot stops itself
						end
					end else if (count_q[c] == 0) begin
						count_q[c] <= reload_q[c];      // started with an empty count
					end else begin
						count_q[c] <= count_q[c] - 1'b1;
					end
				end
				if (wr_ctrl[c]) begin                   // bus writes win
					en_q[c] <= wd.ctrl.enable;
					ar_q[c] <= wd.ctrl.auto_reload;
				end
				if (wr_count[c]) count_q[c] <= wd.count;
				out_q[c] <= en_q[c] && (count_q[c] == 1);
			end
		end
	end

	assign pit_out_o = out_q;

	// ====================
	// read side
	// ====================
	always_comb begin
		rd_ctrl = '0;
		rd_word = '0;
		for (int c = 0; c < NUM_PIT_CH; c++) begin
			if (reg_ok && (reg_ch == 2'(c))) begin
				rd_ctrl.ctrl.enable      = en_q[c];
				rd_ctrl.ctrl.auto_reload = ar_q[c];
				case (reg_off)
					PIT_REG_CTRL:   rd_word = rd_ctrl;
					PIT_REG_RELOAD: rd_word = reload_q[c];
					PIT_REG_COUNT:  rd_word = count_q[c];   // live value
					default:        rd_word = '0;
				endcase
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) ack_q <= 1'b0;
		else          ack_q <= bus.req;
	end

	always_ff @(posedge clk_i) begin
		if (bus.req) rdat_q <= rd_word;
	end

	assign bus.ack  = ack_q;
	assign bus.rdat = rdat_q;

	// a reload above one always leaves idle clocks between pulses
	for (genvar g = 0; g < NUM_PIT_CH; g++) begin : g_chk
		a_pulse_1clk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
			(out_q[g] && ar_q[g] && (reload_q[g] > 1)) |=> !out_q[g]);
	end

endmodule

`default_nettype wire

// File: pic/mpu_pic.sv
`default_nettype none

module mpu_pic (
	input  logic                            clk_i,
	input  logic                            rst_n_i,
	periph_bus_if.periph_mp                 bus,
	input  logic [mpu_pkg::NUM_EXT_IRQ-1:0] irq_i,
	input  logic [mpu_pkg::NUM_PIT_CH-1:0]  pit_out_i,
	output logic [mpu_pkg::LEVEL_W-1:0]     irq_o,
	output logic [mpu_pkg::CAUSE_W-1:0]     cause_o
);
	import mpu_pkg::*;

	logic [NUM_IRQ-1:0] src;          // all sources in package order
	logic [NUM_IRQ-1:0] src_q;        // last sample, for edge detect
	logic [NUM_IRQ-1:0] pending_q;
	logic [NUM_IRQ-1:0] enable_q;
	logic [NUM_IRQ-1:0] active;       // pending and enabled
	logic [NUM_IRQ-1:0] clr;          // write-one-to-clear mask
	logic [LEVEL_W-1:0] level_q;
	logic [CAUSE_W-1:0] cause_nxt;
	logic               any_act;
	logic               wr_en;
	logic               ack_q;
	logic [DATA_W-1:0]  rd_word;
	logic [DATA_W-1:0]  rdat_q;

	// timer ch0 lands on the top source, like the time slice in the full node
	assign src     = {pit_out_i[0], pit_out_i[1], pit_out_i[2], irq_i};
	assign active  = pending_q & enable_q;
	assign any_act = (|active) && (level_q != '0);  // level 0 masks everything
	assign wr_en   = bus.req && bus.we;
	assign clr     = (wr_en && bus.idx == PIC_REG_PENDING) ? bus.wdat[NUM_IRQ-1:0] : '0;

	// ====================
	// edge capture
	// ====================
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			src_q     <= '0;
			pending_q <= '0;
		end else begin
			src_q     <= src;
			pending_q <= (pending_q & ~clr) | (src & ~src_q);  // a new edge beats a clear
		end
	end

	// config registers
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			enable_q <= '0;
			level_q  <= '0;
		end else if (wr_en) begin
			if (bus.idx == PIC_REG_ENABLE) enable_q <= bus.wdat[NUM_IRQ-1:0];
			if (bus.idx == PIC_REG_LEVEL)  level_q  <= bus.wdat[LEVEL_W-1:0];
		end
	end

	// ====================
	// priority select
	// ====================
	always_comb begin
		cause_nxt = '0;
		for (int s = 0; s < NUM_IRQ; s++) begin
			if (active[s]) cause_nxt = CAUSE_W'(s);  // highest number wins
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			irq_o   <= '0;
			cause_o <= '0;
		end else begin
			irq_o   <= any_act ? level_q : '0;
			cause_o <= any_act ? cause_nxt : '0;
		end
	end

	// bus read side
	always_comb begin
		case (bus.idx)
			PIC_REG_PENDING: rd_word = pending_q;
			PIC_REG_ENABLE:  rd_word = enable_q;
			PIC_REG_CAUSE:   rd_word = DATA_W'(cause_o);
			PIC_REG_LEVEL:   rd_word = DATA_W'(level_q);
			default:         rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) ack_q <= 1'b0;
		else          ack_q <= bus.req;
	end

	always_ff @(posedge clk_i) begin
		if (bus.req) rdat_q <= rd_word;
	end

	assign bus.ack  = ack_q;
	assign bus.rdat = rdat_q;

	// the cpu never sees a cause without a level
	a_cause_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(irq_o == '0) |-> (cause_o == '0));

endmodule

`default_nettype wire

// File: design/mpu_periph_top.sv
`default_nettype none

module mpu_periph_top (
	input  logic                            clk_i,
	input  logic                            rst_n_i,
	input  logic                            cyc_i,
	input  logic                            stb_i,
	input  logic                            we_i,
	input  logic [mpu_pkg::ADDR_W-1:0]      adr_i,
	input  logic [mpu_pkg::DATA_W-1:0]      dat_i,
	output logic [mpu_pkg::DATA_W-1:0]      dat_o,
	output logic                            ack_o,
	output logic                            err_o,
	input  logic [mpu_pkg::NUM_EXT_IRQ-1:0] irq_i,
	output logic [mpu_pkg::LEVEL_W-1:0]     irq_o,
	output logic [mpu_pkg::CAUSE_W-1:0]     cause_o,
	output logic [mpu_pkg::NUM_PIT_CH-1:0]  pit_out_o
);
	import mpu_pkg::*;

	logic [NUM_PIT_CH-1:0] pit_out;  // timer pulses, also interrupt sources

	// ====================
	// fabric to peripherals
	// ====================
	periph_bus_if pit_bus ();
	periph_bus_if pic_bus ();

	mpu_bus_fabric u_fabric (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.cyc_i   (cyc_i),
		.stb_i   (stb_i),
		.we_i    (we_i),
		.adr_i   (adr_i),
		.dat_i   (dat_i),
		.dat_o   (dat_o),
		.ack_o   (ack_o),
		.err_o   (err_o),
		.pit_bus (pit_bus.fabric_mp),
		.pic_bus (pic_bus.fabric_mp)
	);

	mpu_pit u_pit (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.bus       (pit_bus.periph_mp),
		.pit_out_o (pit_out)
	);

	mpu_pic u_pic (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.bus       (pic_bus.periph_mp),
		.irq_i     (irq_i),
		.pit_out_i (pit_out),    // sources 29..31
		.irq_o     (irq_o),
		.cause_o   (cause_o)
	);

	assign pit_out_o = pit_out;

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none

// free-running clock and a synchronous reset pulse for the testbench
module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);
	localparam int PERIOD       = 8;
	localparam int RESET_CYCLES = 16;

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	// release just after an edge, like every other driven input
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1 rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

// File: testbench/tb_mpu_periph.sv
`default_nettype none

module tb_mpu_periph;
	import mpu_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 16;
	localparam int BUS_LATENCY  = 2;    // strobe edge to ack_o
	localparam int MAX_LAT      = 16;   // give up on a lost ack
	// ====================
	// cycle budget per test
	// ====================
	localparam int RW_CYCLES       = 400;
	localparam int UNMAPPED_CYCLES = 200;
	localparam int PERIODIC_CYCLES = 1600;
	localparam int ONESHOT_CYCLES  = 600;
	localparam int PRIORITY_CYCLES = 400;
	localparam int PIT_PIC_CYCLES  = 800;
	localparam int TEST_CYCLES     = RW_CYCLES + UNMAPPED_CYCLES + PERIODIC_CYCLES
		+ ONESHOT_CYCLES + PRIORITY_CYCLES + PIT_PIC_CYCLES;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + TEST_CYCLES / 4;

	logic                   clk;
	logic                   rst_n;
	logic                   cyc;
	logic                   stb;
	logic                   we;
	logic [ADDR_W-1:0]      adr;
	logic [DATA_W-1:0]      dat_w;       // toward the dut
	logic [DATA_W-1:0]      dat_r;       // from the dut
	logic                   ack;
	logic                   err;
	logic [NUM_EXT_IRQ-1:0] irq_in;
	logic [LEVEL_W-1:0]     irq_lvl;
	logic [CAUSE_W-1:0]     cause;
	logic [NUM_PIT_CH-1:0]  pit_out;
	logic                   last_err;    // err_o seen with the last ack
	int unsigned            seed_val;

	tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

	mpu_periph_top dut_i (
		.clk_i (clk), .rst_n_i (rst_n),
		.cyc_i (cyc), .stb_i (stb), .we_i (we),
		.adr_i (adr), .dat_i (dat_w), .dat_o (dat_r),
		.ack_o (ack), .err_o (err),
		.irq_i (irq_in), .irq_o (irq_lvl), .cause_o (cause),
		.pit_out_o (pit_out)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// ====================
	// compare tasks
	// ====================
	task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		if (act !== exp)
			abort_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_irq(input string name, input logic [LEVEL_W-1:0] exp,
		input logic [LEVEL_W-1:0] act);
		if (act !== exp)
			abort_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_cause(input string name, input logic [CAUSE_W-1:0] exp,
		input logic [CAUSE_W-1:0] act);
		if (act !== exp)
			abort_run($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_err(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
	endtask

	// address builders with the word index in adr[7:2]
	function automatic logic [ADDR_W-1:0] pit_addr(input int ch, input logic [1:0] off);
		logic [REG_IDX_W-1:0] idx;
		idx = REG_IDX_W'(ch * 4) + REG_IDX_W'(off);
		return {PIT_PAGE, idx, 2'b00};
	endfunction

	function automatic logic [ADDR_W-1:0] pic_addr(input logic [REG_IDX_W-1:0] idx);
		return {PIC_PAGE, idx, 2'b00};
	endfunction

	function automatic logic [DATA_W-1:0] pit_ctrl_word(input logic en, input logic ar);
		pit_wdata_u w;
		w                  = '0;
		w.ctrl.enable      = en;
		w.ctrl.auto_reload = ar;
		return w;
	endfunction

	// ====================
	// bus master
	// ====================
	task automatic run_access(input logic wr, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
		int lat;
		@(posedge clk);     // one idle cycle so the fabric sees stb low
		#1;
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = wr;
		adr   = addr;
		dat_w = wdata;
		lat   = -1;         // the first edge only samples the strobe
		do begin
			@(posedge clk);
			#1;
			lat++;
		end while (!ack && lat < MAX_LAT);
		if (!ack) abort_run($sformatf("no ack_o within %0d cycles of the strobe", MAX_LAT));
		rdata    = dat_r;
		last_err = err;
		cyc      = 1'b0;   // drop in the cycle after ack_o
		stb      = 1'b0;
		we       = 1'b0;
		if (lat != BUS_LATENCY)
			abort_run($sformatf("ack_o came %0d cycles after the strobe, not %0d", lat, BUS_LATENCY));
	endtask

	task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] unused;
		run_access(1'b1, addr, data, unused);
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		run_access(1'b0, addr, '0, data);
	endtask

	// pulses on one timer output sampled once per cycle
	task automatic count_pulses(input int ch, input int cycles, output int n);
		n = 0;
		repeat (cycles) begin
			@(posedge clk);
			#1;
			if (|(pit_out & (NUM_PIT_CH'(1) << ch))) n++;
		end
	endtask

	// ====================
	// directed tests
	// ====================
	task automatic test_register_rw();
		logic [DATA_W-1:0] vals [$];
		logic [DATA_W-1:0] en_val;
		logic [DATA_W-1:0] lvl_val;
		logic [DATA_W-1:0] rd;
		for (int ch = 0; ch < NUM_PIT_CH; ch++) begin
			vals.push_back($urandom);
			bus_write(pit_addr(ch, PIT_REG_RELOAD), vals[ch]);
		end
		en_val  = $urandom;
		lvl_val = DATA_W'($urandom % 16);   // LEVEL holds 4 bits only
		bus_write(pic_addr(PIC_REG_ENABLE), en_val);
		bus_write(pic_addr(PIC_REG_LEVEL), lvl_val);
		for (int ch = 0; ch < NUM_PIT_CH; ch++) begin
			bus_read(pit_addr(ch, PIT_REG_RELOAD), rd);
			check_data($sformatf("test_register_rw reload ch%0d", ch), vals[ch], rd);
		end
		bus_read(pic_addr(PIC_REG_ENABLE), rd);
		check_data("test_register_rw enable", en_val, rd);
		bus_read(pic_addr(PIC_REG_LEVEL), rd);
		check_data("test_register_rw level", lvl_val, rd);
		bus_write(pic_addr(PIC_REG_ENABLE), '0);   // quiet controller for what follows
		bus_write(pic_addr(PIC_REG_LEVEL), '0);
	endtask

	task automatic test_unmapped();
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] rd;
		addr = 32'h1234_5670;   // page 123456 is neither peripheral
		bus_write(addr, $urandom);
		check_err("test_unmapped write err", 1'b1, last_err);
		bus_read(addr, rd);
		check_err("test_unmapped read err", 1'b1, last_err);
		check_data("test_unmapped read data", '0, rd);
		bus_read(pic_addr(PIC_REG_LEVEL), rd);
		check_err("test_unmapped mapped err", 1'b0, last_err);
	endtask

	task automatic test_pit_periodic();
		int r;
		int pulses;
		r = 4 + int'($urandom % 13);
		bus_write(pit_addr(0, PIT_REG_RELOAD), DATA_W'(r));
		bus_write(pit_addr(0, PIT_REG_CTRL), pit_ctrl_word(1'b1, 1'b1));
		count_pulses(0, 10 * r, pulses);
		if (pulses < 9 || pulses > 10)
			abort_run($sformatf("test_pit_periodic saw %0d pulses in %0d cycles, wanted 9 or 10",
				pulses, 10 * r));
		bus_write(pit_addr(0, PIT_REG_CTRL), pit_ctrl_word(1'b0, 1'b0));
		count_pulses(0, 3 * r, pulses);
		check_data("test_pit_periodic pulses after stop", '0, DATA_W'(pulses));
	endtask

	task automatic test_pit_oneshot();
		int n;
		int pulses;
		logic [DATA_W-1:0] rd;
		n = 10 + int'($urandom % 20);
		bus_write(pit_addr(1, PIT_REG_COUNT), DATA_W'(n));
		bus_write(pit_addr(1, PIT_REG_CTRL), pit_ctrl_word(1'b1, 1'b0));
		count_pulses(1, n + 10, pulses);   // pulse lands n cycles after enable
		check_data("test_pit_oneshot pulses", 32'd1, DATA_W'(pulses));
		bus_read(pit_addr(1, PIT_REG_CTRL), rd);
		check_data("test_pit_oneshot ctrl", pit_ctrl_word(1'b0, 1'b0), rd);
		bus_read(pit_addr(1, PIT_REG_COUNT), rd);
		check_data("test_pit_oneshot count", '0, rd);
	endtask

	task automatic test_pic_priority();
		int a;
		int b;
		int hi;
		int lo;
		logic [LEVEL_W-1:0] lvl;
		lvl = LEVEL_W'(1 + $urandom % 15);   // nonzero since level 0 masks all
		a   = int'($urandom % NUM_EXT_IRQ);
		b   = a;
		while (b == a) b = int'($urandom % NUM_EXT_IRQ);
		hi  = (a > b) ? a : b;
		lo  = (a > b) ? b : a;
		bus_write(pic_addr(PIC_REG_ENABLE), '1);
		bus_write(pic_addr(PIC_REG_LEVEL), DATA_W'(lvl));
		bus_write(pic_addr(PIC_REG_PENDING), '1);   // stale timer edges
		check_irq("test_pic_priority idle level", '0, irq_lvl);
		irq_in = (NUM_EXT_IRQ'(1) << a) | (NUM_EXT_IRQ'(1) << b);
		repeat (2) @(posedge clk);   // one edge to capture and one to register
		#1;
		check_irq("test_pic_priority level", lvl, irq_lvl);
		check_cause("test_pic_priority cause high", CAUSE_W'(hi), cause);
		bus_write(pic_addr(PIC_REG_PENDING), DATA_W'(1) << hi);
		check_irq("test_pic_priority level after clear", lvl, irq_lvl);
		check_cause("test_pic_priority cause low", CAUSE_W'(lo), cause);
		bus_write(pic_addr(PIC_REG_PENDING), DATA_W'(1) << lo);
		check_irq("test_pic_priority level cleared", '0, irq_lvl);
		check_cause("test_pic_priority cause cleared", '0, cause);
		irq_in = '0;
	endtask

	task automatic test_pit_to_pic();
		int r;
		int waited;
		logic [DATA_W-1:0] rd;
		r = 4 + int'($urandom % 13);
		bus_write(pic_addr(PIC_REG_ENABLE), 32'h8000_0000);   // source 31 = timer ch0
		bus_write(pic_addr(PIC_REG_PENDING), '1);
		check_cause("test_pit_to_pic idle cause", '0, cause);
		bus_write(pit_addr(0, PIT_REG_RELOAD), DATA_W'(r));
		bus_write(pit_addr(0, PIT_REG_CTRL), pit_ctrl_word(1'b1, 1'b1));
		waited = 0;
		while (cause != CAUSE_W'(31) && waited < 4 * r + 16) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (cause != CAUSE_W'(31))
			abort_run($sformatf("test_pit_to_pic cause_o never reached 31 in %0d cycles", waited));
		bus_read(pic_addr(PIC_REG_CAUSE), rd);
		check_data("test_pit_to_pic cause read", 32'd31, rd);
		bus_write(pit_addr(0, PIT_REG_CTRL), pit_ctrl_word(1'b0, 1'b0));
	endtask

	// ====================
	// run
	// ====================
	initial begin
		cyc      = 1'b0;
		stb      = 1'b0;
		we       = 1'b0;
		adr      = '0;
		dat_w    = '0;
		irq_in   = '0;
		last_err = 1'b0;
		seed_val = $urandom(69);
		wait (rst_n === 1'b1);
		test_register_rw();
		test_unmapped();
		test_pit_periodic();
		test_pit_oneshot();
		test_pic_priority();
		test_pit_to_pic();
		$display("Simulation completed successfully");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run($sformatf("watchdog expired after %0d cycles, tests did not finish",
			WATCHDOG_CYCLES));
	end

endmodule

`default_nettype wire

// File: project.f
common/mpu_pkg.sv
common/periph_bus_if.sv
design/mpu_bus_fabric.sv
pit/mpu_pit.sv
pic/mpu_pic.sv
design/mpu_periph_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mpu_periph.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the peripheral complex testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_mpu_periph
BUILD_DIR=obj_dir
BUILD_LOG=build.log
LOG=sim.log

verilator --binary --timing --assert \
	--top-module "$TOP" --Mdir "$BUILD_DIR" -o "V$TOP" \
	-f project.f > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
	echo "FAIL: testbench reported failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "FAIL: simulation exited with status $status"
	exit 1
fi
echo "PASS"
exit 0
